/* Bender.yml */
package:
  name: aim_overlay

sources:
  - logic/overlay_pkg.sv
  - logic/box_regs.sv
  - logic/box_overlay.sv
  - logic/pack_switch.sv
  - logic/aim_overlay_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/aim_overlay_asserts.sv
      - dv/aim_overlay_tb.sv

/* dv/aim_overlay_asserts.sv */
module aim_overlay_asserts
    import overlay_pkg::*;
#(
    parameter int N_BOX  = 2,
    parameter int BORDER = 2
) (
    input logic                 clk,
    input logic                 i_rst_n,
    input apb_req_t             i_apb,
    input apb_rsp_t             o_apb,
    input pixel_pack_t          i_pack_1,
    input pixel_pack_t          i_pack_2,
    input pixel_pack_t          o_pack,
    input logic                 o_cam_sel
);

    box_t [N_BOX-1:0] sh_boxes;
    logic             sh_cam;
    logic             access;
    logic             mapped;
    int               box_n;
    logic [3:0]       off;
    logic [31:0]      exp_rd;
    pixel_pack_t      pix_1;
    pixel_pack_t      pix_2;
    pixel_pack_t      ov_1;
    pixel_pack_t      ov_2;
    pixel_pack_t      exp_pack;
    logic             act_sel;
    logic             exp_cam;
    int               err_cnt = 0;

    // outline colour of the lowest box whose border covers the pixel, else the pixel's own
    function automatic logic [23:0] draw_color(pixel_pack_t p, box_t [N_BOX-1:0] bx);
        logic [23:0] c;
        logic        found;
        int          px;
        int          py;
        logic        on_edge;
        c     = {p.r, p.g, p.b};
        found = 1'b0;
        px    = int'(p.x);
        py    = int'(p.y);
        for (int k = 0; k < N_BOX; k++) begin
            on_edge = (px - int'(bx[k].start_x) < BORDER) || (int'(bx[k].end_x) - px < BORDER) ||
                      (py - int'(bx[k].start_y) < BORDER) || (int'(bx[k].end_y) - py < BORDER);
            if (!found && p.de && bx[k].en && on_edge &&
                px >= int'(bx[k].start_x) && px <= int'(bx[k].end_x) &&
                py >= int'(bx[k].start_y) && py <= int'(bx[k].end_y)) begin
                c     = bx[k].color;
                found = 1'b1;
            end
        end
        return c;
    endfunction

    assign access = i_apb.psel && i_apb.penable;
    assign off    = i_apb.paddr[3:0];

    always_comb begin
        box_n  = -1;
        mapped = 1'b0;
        exp_rd = '0;
        if (i_apb.paddr == 8'h00) begin
            mapped    = 1'b1;
            exp_rd[0] = sh_cam;
        end else if (i_apb.paddr >= 8'h10 && int'(i_apb.paddr) < 16 + 16 * N_BOX &&
                     off inside {4'h0, 4'h4, 4'h8}) begin
            mapped = 1'b1;
            box_n  = int'(i_apb.paddr[7:4]) - 1;
            case (off)
                4'h0: begin
                    exp_rd[10:0]  = sh_boxes[box_n].start_x;
                    exp_rd[25:16] = sh_boxes[box_n].start_y;
                end
                4'h4: begin
                    exp_rd[10:0]  = sh_boxes[box_n].end_x;
                    exp_rd[25:16] = sh_boxes[box_n].end_y;
                end
                default: begin
                    exp_rd[23:0] = sh_boxes[box_n].color;
                    exp_rd[24]   = sh_boxes[box_n].en;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sh_boxes <= '0;
            sh_cam   <= 1'b0;
        end else if (access && i_apb.pwrite && mapped) begin
            if (box_n < 0) begin
                sh_cam <= i_apb.pwdata[0];
            end else if (off == 4'h0) begin
                sh_boxes[box_n].start_x <= i_apb.pwdata[10:0];
                sh_boxes[box_n].start_y <= i_apb.pwdata[25:16];
            end else if (off == 4'h4) begin
                sh_boxes[box_n].end_x <= i_apb.pwdata[10:0];
                sh_boxes[box_n].end_y <= i_apb.pwdata[25:16];
            end else begin
                sh_boxes[box_n].color <= i_apb.pwdata[23:0];
                sh_boxes[box_n].en    <= i_apb.pwdata[24];
            end
        end
    end

    always_comb begin
        pix_1 = i_pack_1;
        pix_2 = i_pack_2;
        {pix_1.r, pix_1.g, pix_1.b} = draw_color(i_pack_1, sh_boxes);
        {pix_2.r, pix_2.g, pix_2.b} = draw_color(i_pack_2, sh_boxes);
    end

    // first delay stage is the overlaid pair, the second is the shown stream
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ov_1     <= '0;
            ov_2     <= '0;
            exp_pack <= '0;
            act_sel  <= 1'b0;
            exp_cam  <= 1'b0;
        end else begin
            ov_1     <= pix_1;
            ov_2     <= pix_2;
            exp_pack <= act_sel ? ov_2 : ov_1;
            exp_cam  <= act_sel;
            if ((act_sel ? ov_2.vsync : ov_1.vsync)) begin
                act_sel <= sh_cam;                  // new camera from the cycle after vsync
            end
        end
    end

    a_pready: assert property (@(posedge clk) disable iff (!i_rst_n) o_apb.pready)
        else begin
            $error("FAIL t=%0t o_apb.pready exp=1 got=%b", $time, $sampled(o_apb.pready));
            err_cnt++;
        end

    a_pslverr: assert property (@(posedge clk) disable iff (!i_rst_n)
        access |-> o_apb.pslverr == !mapped)
        else begin
            $error("FAIL t=%0t o_apb.pslverr exp=%b got=%b", $time,
                   !$sampled(mapped), $sampled(o_apb.pslverr));
            err_cnt++;
        end

    a_prdata: assert property (@(posedge clk) disable iff (!i_rst_n)
        access && !i_apb.pwrite |-> o_apb.prdata == exp_rd)
        else begin
            $error("FAIL t=%0t o_apb.prdata exp=%h got=%h", $time,
                   $sampled(exp_rd), $sampled(o_apb.prdata));
            err_cnt++;
        end

    a_sync: assert property (@(posedge clk) disable iff (!i_rst_n)
        {o_pack.de, o_pack.hsync, o_pack.vsync, o_pack.x, o_pack.y} ==
        {exp_pack.de, exp_pack.hsync, exp_pack.vsync, exp_pack.x, exp_pack.y})
        else begin
            $error("FAIL t=%0t o_pack.sync exp=%h got=%h", $time,
                   $sampled({exp_pack.de, exp_pack.hsync, exp_pack.vsync, exp_pack.x, exp_pack.y}),
                   $sampled({o_pack.de, o_pack.hsync, o_pack.vsync, o_pack.x, o_pack.y}));
            err_cnt++;
        end

    a_color: assert property (@(posedge clk) disable iff (!i_rst_n)
        {o_pack.r, o_pack.g, o_pack.b} == {exp_pack.r, exp_pack.g, exp_pack.b})
        else begin
            $error("FAIL t=%0t o_pack.rgb exp=%h got=%h", $time,
                   $sampled({exp_pack.r, exp_pack.g, exp_pack.b}),
                   $sampled({o_pack.r, o_pack.g, o_pack.b}));
            err_cnt++;
        end

    a_cam_sel: assert property (@(posedge clk) disable iff (!i_rst_n) o_cam_sel == exp_cam)
        else begin
            $error("FAIL t=%0t o_cam_sel exp=%b got=%b", $time,
                   $sampled(exp_cam), $sampled(o_cam_sel));
            err_cnt++;
        end

endmodule : aim_overlay_asserts

/* dv/aim_overlay_tb.sv */
module aim_overlay_tb
    import overlay_pkg::*;
;

    localparam int N_BOX       = 2;
    localparam int BORDER      = 2;
    localparam int H_ACT       = 32;
    localparam int H_TOT       = 40;
    localparam int V_ACT       = 16;
    localparam int V_TOT       = 20;
    localparam int FRAME_CYC   = H_TOT * V_TOT;
    localparam int CYCLE_LIMIT = 12 * FRAME_CYC + 200;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    pixel_pack_t pack_1;
    pixel_pack_t pack_2;
    pixel_pack_t pack_out;
    logic        cam_sel;
    logic [31:0] rnd_1;
    logic [31:0] rnd_2;
    int          seed = 32'h5197;
    int          h_1;
    int          v_1;
    int          h_2;
    int          v_2;
    int          cycles;
    int          stim_errs;
    int          timeouts;

    tb_clk_gen #(.PERIOD(4)) u_clk (.o_clk(clk));

    aim_overlay_top #(
        .N_BOX (N_BOX ),
        .BORDER(BORDER)
    ) u_dut (
        .clk      (clk     ),
        .i_rst_n  (rst_n   ),
        .i_apb    (apb_req ),
        .o_apb    (apb_rsp ),
        .i_pack_1 (pack_1  ),
        .i_pack_2 (pack_2  ),
        .o_pack   (pack_out),
        .o_cam_sel(cam_sel )
    );

    bind aim_overlay_top aim_overlay_asserts #(
        .N_BOX (N_BOX ),
        .BORDER(BORDER)
    ) u_asserts (
        .clk      (clk      ),
        .i_rst_n  (i_rst_n  ),
        .i_apb    (i_apb    ),
        .o_apb    (o_apb    ),
        .i_pack_1 (i_pack_1 ),
        .i_pack_2 (i_pack_2 ),
        .o_pack   (o_pack   ),
        .o_cam_sel(o_cam_sel)
    );

    function automatic pixel_pack_t make_pixel(int h, int v, logic [23:0] rgb);
        pixel_pack_t p;
        p       = '0;
        p.de    = (h < H_ACT) && (v < V_ACT);
        p.hsync = (h >= H_ACT + 2) && (h < H_ACT + 5);
        p.vsync = (v >= V_ACT + 1) && (v < V_ACT + 3);  // two lines of vsync
        p.x     = X_W'(h);
        p.y     = Y_W'(v);
        if (p.de) begin
            {p.r, p.g, p.b} = rgb;
        end
        return p;
    endfunction

    task automatic step_pos(inout int h, inout int v);
        h = h + 1;
        if (h == H_TOT) begin
            h = 0;
            v = (v + 1 == V_TOT) ? 0 : v + 1;
        end
    endtask

    // both cameras run the same raster, camera 2 starts part way into its frame
    always @(negedge clk) begin
        step_pos(h_1, v_1);
        step_pos(h_2, v_2);
        rnd_1  = $random(seed);
        rnd_2  = $random(seed);
        pack_1 = make_pixel(h_1, v_1, rnd_1[23:0]);
        pack_2 = make_pixel(h_2, v_2, rnd_2[23:0]);
    end

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic read_all();
        apb_xfer(1'b0, REG_CTRL, '0);
        for (int k = 0; k < N_BOX; k++) begin
            apb_xfer(1'b0, 8'(REG_START + 16 * k), '0);
            apb_xfer(1'b0, 8'(REG_END + 16 * k), '0);
            apb_xfer(1'b0, 8'(REG_COLOR + 16 * k), '0);
        end
    endtask

    task automatic set_box(input int k, input int sx, input int sy, input int ex, input int ey,
                           input logic [23:0] color, input logic en);
        apb_xfer(1'b1, 8'(REG_START + 16 * k), (32'(sy) << 16) | 32'(sx));
        apb_xfer(1'b1, 8'(REG_END + 16 * k), (32'(ey) << 16) | 32'(ex));
        apb_xfer(1'b1, 8'(REG_COLOR + 16 * k), {7'b0, en, color});
    endtask

    task automatic wait_frames(input int n);
        for (int i = 0; i < n; i++) begin
            while (!pack_out.vsync) @(negedge clk);
            while (pack_out.vsync) @(negedge clk);
        end
    endtask

    task automatic wait_cam(input logic want);
        int n;
        n = 0;
        while (cam_sel !== want && n < 2 * FRAME_CYC) begin
            @(negedge clk);
            n++;
        end
        if (cam_sel !== want) begin
            $display("camera select did not change to %0d within two frames", want);
            stim_errs++;
        end
    endtask

    task automatic finish_run();
        int assert_errs;
        assert_errs = u_dut.u_asserts.err_cnt;
        $display("errors: assertion=%0d stimulus=%0d timeout=%0d",
                 assert_errs, stim_errs, timeouts);
        if (assert_errs + stim_errs + timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            timeouts++;
            finish_run();
        end
    end

    initial begin
        apb_req   = '0;
        pack_1    = '0;
        pack_2    = '0;
        rst_n     = 1'b0;
        cycles    = 0;
        stim_errs = 0;
        timeouts  = 0;
        h_1       = 0;
        v_1       = 0;
        h_2       = 13;
        v_2       = 7;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_all();
        apb_xfer(1'b1, 8'h30, 32'hFFFF_FFFF);  // past the last box
        apb_xfer(1'b1, 8'h1C, 32'hFFFF_FFFF);  // hole inside box 0
        apb_xfer(1'b1, 8'h16, 32'hFFFF_FFFF);  // not word aligned
        apb_xfer(1'b1, 8'h04, 32'hFFFF_FFFF);
        apb_xfer(1'b0, 8'h30, '0);
        apb_xfer(1'b0, 8'h16, '0);
        read_all();

        // all ones shows which bits each register keeps
        for (int k = 0; k < N_BOX; k++) begin
            apb_xfer(1'b1, 8'(REG_START + 16 * k), 32'hFFFF_FFFF);
            apb_xfer(1'b1, 8'(REG_END + 16 * k), 32'hFFFF_FFFF);
            apb_xfer(1'b1, 8'(REG_COLOR + 16 * k), 32'hFEFF_FFFF);
        end
        read_all();

        set_box(0, 4, 3, 20, 12, 24'hFF_00_00, 1'b0);
        set_box(1, 10, 8, 28, 15, 24'h00_FF_00, 1'b0);
        wait_frames(1);
        set_box(0, 4, 3, 20, 12, 24'hFF_00_00, 1'b1);
        wait_frames(1);
        set_box(1, 10, 8, 28, 15, 24'h00_FF_00, 1'b1);  // outlines cross box 0
        wait_frames(1);

        apb_xfer(1'b1, REG_CTRL, 32'hFFFF_FFFF);  // only bit 0 is kept
        wait_cam(1'b1);
        wait_frames(1);
        read_all();
        apb_xfer(1'b1, REG_CTRL, 32'hFFFF_FFFE);
        wait_cam(1'b0);
        wait_frames(1);
        finish_run();
    end

endmodule : aim_overlay_tb

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule : tb_clk_gen

/* logic/aim_overlay_top.sv */
module aim_overlay_top
    import overlay_pkg::*;
#(
    parameter int N_BOX  = 2,
    parameter int BORDER = 2
) (
    input  logic        clk,
    input  logic        i_rst_n,

    input  apb_req_t    i_apb,
    output apb_rsp_t    o_apb,

    input  pixel_pack_t i_pack_1,
    input  pixel_pack_t i_pack_2,

    output pixel_pack_t o_pack,
    output logic        o_cam_sel
);

    box_t        [N_BOX-1:0] boxes;
    logic                    cam_sel_pend;
    pixel_pack_t             pack_ov_1;
    pixel_pack_t             pack_ov_2;

    box_regs #(
        .N_BOX(N_BOX)
    ) u_regs (
        .clk      (clk         ),
        .i_rst_n  (i_rst_n     ),
        .i_apb    (i_apb       ),
        .o_apb    (o_apb       ),
        .o_boxes  (boxes       ),
        .o_cam_sel(cam_sel_pend)
    );

    // both cameras share one box set
    box_overlay #(
        .N_BOX (N_BOX ),
        .BORDER(BORDER)
    ) u_overlay_1 (
        .clk    (clk      ),
        .i_rst_n(i_rst_n  ),
        .i_pack (i_pack_1 ),
        .i_boxes(boxes    ),
        .o_pack (pack_ov_1)
    );

    box_overlay #(
        .N_BOX (N_BOX ),
        .BORDER(BORDER)
    ) u_overlay_2 (
        .clk    (clk      ),
        .i_rst_n(i_rst_n  ),
        .i_pack (i_pack_2 ),
        .i_boxes(boxes    ),
        .o_pack (pack_ov_2)
    );

    pack_switch u_switch (
        .clk      (clk         ),
        .i_rst_n  (i_rst_n     ),
        .i_pack_1 (pack_ov_1   ),
        .i_pack_2 (pack_ov_2   ),
        .i_cam_sel(cam_sel_pend),
        .o_pack   (o_pack      ),
        .o_cam_sel(o_cam_sel   )
    );

endmodule : aim_overlay_top

/* logic/box_overlay.sv */
module box_overlay
    import overlay_pkg::*;
#(
    parameter int N_BOX  = 2,
    parameter int BORDER = 2
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  pixel_pack_t             i_pack,
    input  box_t        [N_BOX-1:0] i_boxes,
    output pixel_pack_t             o_pack
);

    logic [N_BOX-1:0] hit;
    pixel_pack_t      pack_d;

    for (genvar k = 0; k < N_BOX; k++) begin : gen_hit
        logic in_x;
        logic in_y;
        logic edge_x;
        logic edge_y;

        assign in_x = (i_pack.x >= i_boxes[k].start_x) && (i_pack.x <= i_boxes[k].end_x);
        assign in_y = (i_pack.y >= i_boxes[k].start_y) && (i_pack.y <= i_boxes[k].end_y);

        // the sums are evaluated at integer width so they never wrap
        assign edge_x = (i_pack.x < i_boxes[k].start_x + BORDER) ||
                        (i_pack.x + BORDER > i_boxes[k].end_x);
        assign edge_y = (i_pack.y < i_boxes[k].start_y + BORDER) ||
                        (i_pack.y + BORDER > i_boxes[k].end_y);

        assign hit[k] = i_pack.de && i_boxes[k].en && in_x && in_y && (edge_x || edge_y);
    end

    always_comb begin
        pack_d = i_pack;
        // walk down so the lowest index is applied last and wins
        for (int k = N_BOX - 1; k >= 0; k--) begin
            if (hit[k]) begin
                {pack_d.r, pack_d.g, pack_d.b} = i_boxes[k].color;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pack <= '0;
        end else begin
            o_pack <= pack_d;
        end
    end

endmodule : box_overlay

/* logic/box_regs.sv */
module box_regs
    import overlay_pkg::*;
#(
    parameter int N_BOX = 2
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  apb_req_t             i_apb,
    output apb_rsp_t             o_apb,
    output box_t     [N_BOX-1:0] o_boxes,
    output logic                 o_cam_sel
);

    logic [3:0]  box_sel;
    logic [3:0]  box_idx;
    logic [7:0]  sub_addr;
    logic        in_box;
    logic        is_ctrl;
    logic        hit_start;
    logic        hit_end;
    logic        hit_color;
    logic        mapped;
    logic        access;
    logic        wr_en;
    logic [31:0] rd_data;

    assign box_sel  = i_apb.paddr[7:4];
    assign box_idx  = box_sel - 4'd1;          // box 0 lives at 0x10
    assign sub_addr = {4'h1, i_apb.paddr[3:0]}; // folds every box onto the box 0 offsets

    assign in_box    = (box_sel != 4'd0) && (box_sel <= N_BOX);
    assign is_ctrl   = (i_apb.paddr == REG_CTRL);
    assign hit_start = in_box && (sub_addr == REG_START);
    assign hit_end   = in_box && (sub_addr == REG_END);
    assign hit_color = in_box && (sub_addr == REG_COLOR);

    // exact offset matches also reject any address that is not word aligned
    assign mapped = is_ctrl || hit_start || hit_end || hit_color;

    assign access = i_apb.psel && i_apb.penable;
    assign wr_en  = access && i_apb.pwrite && mapped;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_boxes   <= '0;
            o_cam_sel <= 1'b0;
        end else if (wr_en) begin
            if (is_ctrl) begin
                o_cam_sel <= i_apb.pwdata[0];
            end
            for (int k = 0; k < N_BOX; k++) begin
                if (box_idx == k) begin
                    if (hit_start) begin
                        o_boxes[k].start_x <= i_apb.pwdata[X_W-1:0];
                        o_boxes[k].start_y <= i_apb.pwdata[REG_Y_LSB +: Y_W];
                    end
                    if (hit_end) begin
                        o_boxes[k].end_x <= i_apb.pwdata[X_W-1:0];
                        o_boxes[k].end_y <= i_apb.pwdata[REG_Y_LSB +: Y_W];
                    end
                    if (hit_color) begin
                        o_boxes[k].color <= i_apb.pwdata[COLOR_W-1:0];
                        o_boxes[k].en    <= i_apb.pwdata[REG_EN_BIT];
                    end
                end
            end
        end
    end

    always_comb begin
        rd_data = '0;
        if (is_ctrl) begin
            rd_data[0] = o_cam_sel;
        end
        for (int k = 0; k < N_BOX; k++) begin
            if (box_idx == k) begin
                if (hit_start) begin
                    rd_data[X_W-1:0]            = o_boxes[k].start_x;
                    rd_data[REG_Y_LSB +: Y_W]   = o_boxes[k].start_y;
                end
                if (hit_end) begin
                    rd_data[X_W-1:0]            = o_boxes[k].end_x;
                    rd_data[REG_Y_LSB +: Y_W]   = o_boxes[k].end_y;
                end
                if (hit_color) begin
                    rd_data[COLOR_W-1:0]        = o_boxes[k].color;
                    rd_data[REG_EN_BIT]         = o_boxes[k].en;
                end
            end
        end
    end

    assign o_apb.prdata  = rd_data;              // zero for anything unmapped
    assign o_apb.pready  = 1'b1;                 // no wait states
    assign o_apb.pslverr = access && !mapped;

endmodule : box_regs

/* logic/overlay_pkg.sv */
package overlay_pkg;

    localparam int X_W     = 11;
    localparam int Y_W     = 10;
    localparam int COLOR_W = 24;

    // field positions inside the box registers
    localparam int REG_Y_LSB  = 16;
    localparam int REG_EN_BIT = 24;

    typedef struct packed {
        logic [7:0]     r;
        logic [7:0]     g;
        logic [7:0]     b;
        logic           de;
        logic           hsync;
        logic           vsync;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } pixel_pack_t;

    typedef struct packed {
        logic [X_W-1:0]     start_x;
        logic [Y_W-1:0]     start_y;
        logic [X_W-1:0]     end_x;
        logic [Y_W-1:0]     end_y;
        logic [COLOR_W-1:0] color;   // r in the top byte, b in the bottom byte
        logic               en;
    } box_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // box registers are given at box 0, box k adds 16*k to the address
    typedef enum logic [7:0] {
        REG_CTRL  = 8'h00,
        REG_START = 8'h10,
        REG_END   = 8'h14,
        REG_COLOR = 8'h18
    } reg_off_e;

endpackage : overlay_pkg

/* logic/pack_switch.sv */
module pack_switch
    import overlay_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  pixel_pack_t i_pack_1,
    input  pixel_pack_t i_pack_2,
    input  logic        i_cam_sel,
    output pixel_pack_t o_pack,
    output logic        o_cam_sel
);

    logic        sel_q;
    pixel_pack_t active;

    assign active = sel_q ? i_pack_2 : i_pack_1;

    // the choice only moves during vsync of the stream on screen
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sel_q <= 1'b0;
        end else if (active.vsync) begin
            sel_q <= i_cam_sel;
        end
    end

    // o_cam_sel is registered with o_pack so it always names the source of o_pack
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pack    <= '0;
            o_cam_sel <= 1'b0;
        end else begin
            o_pack    <= active;
            o_cam_sel <= sel_q;
        end
    end

endmodule : pack_switch

/* sim.f */
logic/overlay_pkg.sv
logic/box_regs.sv
logic/box_overlay.sv
logic/pack_switch.sv
logic/aim_overlay_top.sv
dv/tb_clk_gen.sv
dv/aim_overlay_asserts.sv
dv/aim_overlay_tb.sv
